// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // Width of the instruction fetch read data bus.
    localparam int fetch_data_width = 64;

    // Bits 6:0 of every 32-bit instruction word.
    localparam int opcode_width = 7;

    // Major opcodes from the RV32/RV64 base encoding.
    // Compressed and floating point opcodes are not listed and classify as other.
    typedef enum logic [opcode_width-1:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_system = 7'b1110011
    } opcode_e;

    // Event classes for fetched instructions.
    typedef enum logic [2:0] {
        cls_alu    = 3'd0, // Register and immediate arithmetic, lui, auipc.
        cls_branch = 3'd1, // Conditional branches and both jumps.
        cls_csr    = 3'd2, // The whole system opcode.
        cls_load   = 3'd3,
        cls_store  = 3'd4,
        cls_other  = 3'd5
    } instr_class_e;

endpackage

// File: source/pmu_pkg.sv
package pmu_pkg;

    // All counters share one width, cycles included.
    localparam int counter_width = 64;

    // Counter selection on the read port.
    // Codes 10 to 15 are unused and read as zero.
    typedef enum logic [3:0] {
        cnt_cycles        = 4'd0,
        cnt_instret_fetch = 4'd1,
        cnt_class_alu     = 4'd2,
        cnt_class_branch  = 4'd3,
        cnt_class_csr     = 4'd4,
        cnt_class_load    = 4'd5,
        cnt_class_store   = 4'd6,
        cnt_class_other   = 4'd7,
        cnt_lsu_reads     = 4'd8,
        cnt_lsu_stalls    = 4'd9
    } counter_id_e;

    // Event counts gathered on the fetch read channel.
    typedef struct packed {
        logic [counter_width-1:0] total;
        logic [counter_width-1:0] alu;
        logic [counter_width-1:0] branch;
        logic [counter_width-1:0] csr;
        logic [counter_width-1:0] load;
        logic [counter_width-1:0] store;
        logic [counter_width-1:0] other;
    } fetch_counts_t;

    // Event counts gathered on the load/store read channel.
    typedef struct packed {
        logic [counter_width-1:0] reads;
        logic [counter_width-1:0] stalls;
    } lsu_counts_t;

endpackage

// File: source/fetch_event_counter.sv
`timescale 1ns/1ps

module fetch_event_counter (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  fetch_rvalid,
    input  logic                                  fetch_rready,
    input  logic [rv_isa_pkg::fetch_data_width-1:0] fetch_rdata,
    output pmu_pkg::fetch_counts_t                counts
);
    import rv_isa_pkg::*;
    import pmu_pkg::*;

    logic                    beat;
    logic [opcode_width-1:0] opcode;
    instr_class_e            beat_class;

    assign beat   = fetch_rvalid & fetch_rready;
    assign opcode = fetch_rdata[opcode_width-1:0]; // Only the low word's opcode is decoded.

    // Sort the fetched word into one class by its major opcode.
    always_comb begin
        case (opcode)
            opc_store: begin
                beat_class = cls_store;
            end
            opc_branch, opc_jal, opc_jalr: begin
                beat_class = cls_branch;
            end
            opc_op_imm, opc_op, opc_lui, opc_auipc: begin
                beat_class = cls_alu;
            end
            opc_load: begin
                beat_class = cls_load;
            end
            opc_system: begin
                beat_class = cls_csr;
            end
            default: begin
                beat_class = cls_other;
            end
        endcase
    end

    // One increment of the total and one of the class per accepted beat.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counts <= '0;
        end else if (beat) begin
            counts.total <= counts.total + counter_width'(1);
            case (beat_class)
                cls_alu: begin
                    counts.alu <= counts.alu + counter_width'(1);
                end
                cls_branch: begin
                    counts.branch <= counts.branch + counter_width'(1);
                end
                cls_csr: begin
                    counts.csr <= counts.csr + counter_width'(1);
                end
                cls_load: begin
                    counts.load <= counts.load + counter_width'(1);
                end
                cls_store: begin
                    counts.store <= counts.store + counter_width'(1);
                end
                default: begin
                    counts.other <= counts.other + counter_width'(1);
                end
            endcase
        end
    end

endmodule

// File: source/lsu_event_counter.sv
`timescale 1ns/1ps

module lsu_event_counter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 lsu_rvalid,
    input  logic                 lsu_rready,
    output pmu_pkg::lsu_counts_t counts
);
    import pmu_pkg::*;

    logic read_done;
    logic read_stall;

    // A read completes on the handshake.
    assign read_done = lsu_rvalid & lsu_rready;

    // Data is waiting but the LSU holds it off.
    assign read_stall = lsu_rvalid & ~lsu_rready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counts.reads <= '0;
        end else if (read_done) begin
            counts.reads <= counts.reads + counter_width'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counts.stalls <= '0;
        end else if (read_stall) begin
            counts.stalls <= counts.stalls + counter_width'(1); // At most one per cycle.
        end
    end

endmodule

// File: source/pmu_readout.sv
`timescale 1ns/1ps

module pmu_readout (
    input  logic                              clk,
    input  logic                              rst_n,
    input  pmu_pkg::fetch_counts_t            fetch_counts,
    input  pmu_pkg::lsu_counts_t              lsu_counts,
    input  logic                              rd_req,
    input  pmu_pkg::counter_id_e              rd_id,
    output logic                              rd_ack,
    output logic [pmu_pkg::counter_width-1:0] rd_data
);
    import pmu_pkg::*;

    typedef enum logic {
        st_idle,
        st_acked
    } state_e;

    state_e                   state;
    logic                     req_q;
    logic [counter_width-1:0] cycle_count;
    logic [counter_width-1:0] sel_value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + counter_width'(1);
        end
    end

    // The request is registered once, which gives the one edge delay on both ack edges.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= rd_req;
        end
    end

    always_comb begin
        case (rd_id)
            cnt_cycles:        sel_value = cycle_count;
            cnt_instret_fetch: sel_value = fetch_counts.total;
            cnt_class_alu:     sel_value = fetch_counts.alu;
            cnt_class_branch:  sel_value = fetch_counts.branch;
            cnt_class_csr:     sel_value = fetch_counts.csr;
            cnt_class_load:    sel_value = fetch_counts.load;
            cnt_class_store:   sel_value = fetch_counts.store;
            cnt_class_other:   sel_value = fetch_counts.other;
            cnt_lsu_reads:     sel_value = lsu_counts.reads;
            cnt_lsu_stalls:    sel_value = lsu_counts.stalls;
            default:           sel_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            rd_data <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_q) begin
                        rd_data <= sel_value; // rd_id is still held stable here.
                        state   <= st_acked;
                    end
                end
                default: begin
                    if (!req_q) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    assign rd_ack = (state == st_acked);

endmodule

// File: source/pmu.sv
`timescale 1ns/1ps

module pmu (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    fetch_rvalid,
    input  logic                                    fetch_rready,
    input  logic [rv_isa_pkg::fetch_data_width-1:0] fetch_rdata,
    input  logic                                    lsu_rvalid,
    input  logic                                    lsu_rready,
    input  logic                                    rd_req,
    input  pmu_pkg::counter_id_e                    rd_id,
    output logic                                    rd_ack,
    output logic [pmu_pkg::counter_width-1:0]       rd_data
);
    import pmu_pkg::*;

    fetch_counts_t fetch_counts;
    lsu_counts_t   lsu_counts;

    // Both channels are only observed, so the PMU never applies back-pressure.
    fetch_event_counter fetch_cnt_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rready (fetch_rready),
        .fetch_rdata  (fetch_rdata),
        .counts       (fetch_counts)
    );

    lsu_event_counter lsu_cnt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu_rvalid (lsu_rvalid),
        .lsu_rready (lsu_rready),
        .counts     (lsu_counts)
    );

    pmu_readout readout_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_counts (fetch_counts),
        .lsu_counts   (lsu_counts),
        .rd_req       (rd_req),
        .rd_id        (rd_id),
        .rd_ack       (rd_ack),
        .rd_data      (rd_data)
    );

endmodule

// File: verification/pmu_clock_gen.sv
`timescale 1ns/1ps

module pmu_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 4; // 8 ns clock period.
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period;
            clk = ~clk;
        end
    end

    // Reset is released on a rising edge so that it lines up with the synchronous logic.
    initial begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: verification/pmu_tb.sv
`timescale 1ns/1ps

module pmu_tb;
    import rv_isa_pkg::*;
    import pmu_pkg::*;

    localparam int ack_timeout   = 50;
    localparam int reset_timeout = 20;

    logic                        clk;
    logic                        rst_n;
    logic                        fetch_rvalid;
    logic                        fetch_rready;
    logic [fetch_data_width-1:0] fetch_rdata;
    logic                        lsu_rvalid;
    logic                        lsu_rready;
    logic                        rd_req;
    counter_id_e                 rd_id;
    logic                        rd_ack;
    logic [counter_width-1:0]    rd_data;

    logic [counter_width-1:0] edge_count = '0;
    logic [counter_width-1:0] shadow_total;
    logic [counter_width-1:0] shadow_class [0:5];
    logic [counter_width-1:0] shadow_reads;
    logic [counter_width-1:0] shadow_stalls;

    pmu_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pmu dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rready (fetch_rready),
        .fetch_rdata  (fetch_rdata),
        .lsu_rvalid   (lsu_rvalid),
        .lsu_rready   (lsu_rready),
        .rd_req       (rd_req),
        .rd_id        (rd_id),
        .rd_ack       (rd_ack),
        .rd_data      (rd_data)
    );

    always @(posedge clk) begin
        edge_count <= edge_count + 64'd1; // Places capture edges in time.
    end

    function automatic instr_class_e classify(input logic [31:0] word);
        case (word[6:0])
            opc_store:                              return cls_store;
            opc_branch, opc_jal, opc_jalr:          return cls_branch;
            opc_op_imm, opc_op, opc_lui, opc_auipc: return cls_alu;
            opc_load:                               return cls_load;
            opc_system:                             return cls_csr;
            default:                                return cls_other;
        endcase
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [3:0] idx);
        case (idx)
            4'd0:    return opc_load;
            4'd1:    return opc_store;
            4'd2:    return opc_branch;
            4'd3:    return opc_jal;
            4'd4:    return opc_jalr;
            4'd5:    return opc_op_imm;
            4'd6:    return opc_op;
            4'd7:    return opc_lui;
            4'd8:    return opc_auipc;
            default: return opc_system;
        endcase
    endfunction

    function automatic logic [counter_width-1:0] expected_count(input counter_id_e id);
        case (id)
            cnt_instret_fetch: return shadow_total;
            cnt_class_alu:     return shadow_class[cls_alu];
            cnt_class_branch:  return shadow_class[cls_branch];
            cnt_class_csr:     return shadow_class[cls_csr];
            cnt_class_load:    return shadow_class[cls_load];
            cnt_class_store:   return shadow_class[cls_store];
            cnt_class_other:   return shadow_class[cls_other];
            cnt_lsu_reads:     return shadow_reads;
            cnt_lsu_stalls:    return shadow_stalls;
            default:           return '0;
        endcase
    endfunction

    task automatic report_timeout(input string what);
        $display("Test failures found");
        $fatal(1, "Timed out waiting for %s", what);
    endtask

    task automatic check_value(input string test_name, input logic [counter_width-1:0] expected,
                               input logic [counter_width-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0d actual %0d", test_name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Value mismatch in %s", test_name);
        end
    endtask

    task automatic drive_fetch(input logic valid, input logic ready, input logic [31:0] word);
        instr_class_e cls;
        cls = classify(word);
        @(posedge clk);
        fetch_rvalid <= valid;
        fetch_rready <= ready;
        fetch_rdata  <= {$urandom(), word}; // Only the low word carries the opcode.
        if (valid && ready) begin
            shadow_total      = shadow_total + 64'd1;
            shadow_class[cls] = shadow_class[cls] + 64'd1;
        end
    endtask

    task automatic drive_lsu(input logic valid, input logic ready);
        @(posedge clk);
        lsu_rvalid <= valid;
        lsu_rready <= ready;
        if (valid && ready) begin
            shadow_reads = shadow_reads + 64'd1;
        end else if (valid) begin
            shadow_stalls = shadow_stalls + 64'd1;
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        fetch_rvalid <= 1'b0;
        fetch_rready <= 1'b0;
        lsu_rvalid   <= 1'b0;
        lsu_rready   <= 1'b0;
    endtask

    // Outputs are sampled at the rising edge, so each sample is the value from before it.
    task automatic read_counter(input counter_id_e id, output logic [counter_width-1:0] value,
                                output logic [counter_width-1:0] capture_edge);
        int waited;
        @(posedge clk);
        rd_id        <= id;
        rd_req       <= 1'b1;
        capture_edge = edge_count + 64'd2; // Sampled on the next edge, captured on the one after.
        waited       = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ack_timeout) begin
                report_timeout("rd_ack to rise");
            end
        end while (!rd_ack);
        value  = rd_data;
        rd_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ack_timeout) begin
                report_timeout("rd_ack to fall");
            end
        end while (rd_ack);
    endtask

    task automatic check_counter(input counter_id_e id, input string test_name);
        logic [counter_width-1:0] value;
        logic [counter_width-1:0] capture_edge;
        read_counter(id, value, capture_edge);
        check_value($sformatf("%s %s", test_name, id.name()), expected_count(id), value);
    endtask

    task automatic check_fetch_counters(input string test_name);
        for (int i = 1; i <= 7; i++) begin
            check_counter(counter_id_e'(4'(i)), test_name);
        end
    endtask

    task automatic test_handshake();
        int                       waited;
        logic [counter_width-1:0] held;
        @(posedge clk);
        rd_id  <= cnt_lsu_reads;
        rd_req <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ack_timeout) begin
                report_timeout("rd_ack in the handshake test");
            end
        end while (!rd_ack);
        check_value("ack_rise_latency", 64'd3, 64'(waited));
        check_value("held_read_value", expected_count(cnt_lsu_reads), rd_data);
        held = rd_data;
        // Reads go on while the port is held, and the latched value must not follow them.
        repeat (5) begin
            drive_lsu(1'b1, 1'b1);
            check_value("ack_held_high", 64'd1, 64'(rd_ack));
            check_value("data_held", held, rd_data);
        end
        rd_req <= 1'b0;
        // The drop is sampled on the next edge and rd_ack falls on the edge after that.
        drive_idle();
        @(posedge clk);
        check_value("ack_before_fall", 64'd1, 64'(rd_ack));
        @(posedge clk);
        check_value("ack_after_fall", 64'd0, 64'(rd_ack));
        check_counter(cnt_lsu_reads, "reads_during_ack");
        check_counter(counter_id_e'(4'd12), "undefined_id_12");
        check_counter(counter_id_e'(4'd15), "undefined_id_15");
    endtask

    initial begin
        int                       waited;
        logic [31:0]              word;
        logic [counter_width-1:0] first_value;
        logic [counter_width-1:0] second_value;
        logic [counter_width-1:0] first_edge;
        logic [counter_width-1:0] second_edge;

        void'($urandom(58448));
        fetch_rvalid <= 1'b0;
        fetch_rready <= 1'b0;
        fetch_rdata  <= '0;
        lsu_rvalid   <= 1'b0;
        lsu_rready   <= 1'b0;
        rd_req       <= 1'b0;
        rd_id        <= cnt_cycles;
        shadow_total  = '0;
        shadow_reads  = '0;
        shadow_stalls = '0;
        for (int i = 0; i < 6; i++) begin
            shadow_class[i] = '0;
        end

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > reset_timeout) begin
                report_timeout("reset release");
            end
        end

        check_value("ack_after_reset", 64'd0, 64'(rd_ack));
        for (int i = 1; i <= 9; i++) begin
            check_counter(counter_id_e'(4'(i)), "after_reset");
        end

        drive_fetch(1'b1, 1'b1, 32'h00100093); // addi
        drive_fetch(1'b1, 1'b1, 32'h000012b7); // lui
        drive_fetch(1'b1, 1'b1, 32'h00000063); // beq
        drive_fetch(1'b1, 1'b1, 32'h0000006f); // jal
        drive_fetch(1'b1, 1'b1, 32'h34011073); // csrrw
        drive_fetch(1'b1, 1'b1, 32'h0000a103); // lw
        drive_fetch(1'b1, 1'b1, 32'h0020a023); // sw
        drive_fetch(1'b1, 1'b1, 32'h0000007f); // Opcode outside the base set.
        drive_fetch(1'b1, 1'b0, 32'h00100093);
        drive_fetch(1'b0, 1'b1, 32'h00000063);
        drive_idle();
        check_fetch_counters("directed_fetch");

        // Most words get a known opcode so that every class sees traffic.
        repeat (400) begin
            word = $urandom();
            if ($urandom_range(0, 3) != 0) begin
                word[6:0] = pick_opcode(4'($urandom_range(0, 9)));
            end
            drive_fetch($urandom_range(0, 3) != 0, $urandom_range(0, 3) != 0, word);
        end
        drive_idle();
        check_fetch_counters("random_fetch");

        repeat (300) begin
            drive_lsu($urandom_range(0, 1) == 1, $urandom_range(0, 2) != 0);
        end
        drive_idle();
        check_counter(cnt_lsu_reads, "random_lsu");
        check_counter(cnt_lsu_stalls, "random_lsu");

        read_counter(cnt_cycles, first_value, first_edge);
        repeat (13) @(posedge clk);
        read_counter(cnt_cycles, second_value, second_edge);
        check_value("cycle_delta", second_edge - first_edge, second_value - first_value);

        test_handshake();

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: compile.f
source/rv_isa_pkg.sv
source/pmu_pkg.sv
source/fetch_event_counter.sv
source/lsu_event_counter.sv
source/pmu_readout.sv
source/pmu.sv
verification/pmu_clock_gen.sv
verification/pmu_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps \
		-f compile.f --top-module pmu_tb -Mdir obj_dir -o pmu_sim
	./obj_dir/pmu_sim

clean:
	rm -rf obj_dir
